/* tb.f */
+incdir+hw
hw/raybox_pkg.sv
hw/settings_if.sv
hw/spi_frame_rx.sv
hw/reg_stage.sv
hw/live_regs.sv
hw/spi_registers.sv
verif/spi_registers_asserts.sv
verif/tb_spi_registers.sv

/* Bender.yml */
package:
  name: raybox_spi_registers

sources:
  - include_dirs:
      - hw
    files:
      - hw/raybox_pkg.sv
      - hw/settings_if.sv
      - hw/spi_frame_rx.sv
      - hw/reg_stage.sv
      - hw/live_regs.sv
      - hw/spi_registers.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/spi_registers_asserts.sv
      - verif/tb_spi_registers.sv

/* verif/tb_spi_registers.sv */
`timescale 1ns/10ps
`include "raybox_config.svh"

module tb_spi_registers;

  localparam int NF        = 17;  // Settings fields in the model
  localparam int DONE_WAIT = 40;  // Clocks allowed for the done pulse

  logic        clk, reset;
  logic        i_sclk, i_ss_n, i_mosi, i_load_new;
  logic [5:0]  o_sky, o_floor, o_leak, o_otherx, o_othery, o_vshift;
  logic        o_vinf;
  logic [5:0]  o_mapdx, o_mapdy;
  logic [1:0]  o_mapdxw, o_mapdyw;
  logic [19:0] o_player_x, o_player_y, o_facing_x, o_facing_y, o_vplane_x, o_vplane_y;

  logic [19:0] wait_f [NF];  // Waiting bank model as raw packed codes
  logic [19:0] live_f [NF];  // Live bank model
  string field_name [NF] = '{"sky", "floor", "leak", "otherx", "othery", "vshift", "vinf",
                             "mapdx", "mapdy", "mapdxw", "mapdyw", "player_x", "player_y",
                             "facing_x", "facing_y", "vplane_x", "vplane_y"};
  int errors       = 0;
  int done_cnt     = 0;  // Frame done pulses seen
  int assert_fails = 0;  // Failures from the bound checkers

  spi_registers UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Count completed frames from the receiver
  always @(posedge clk) if (UUT.frame_done) done_cnt <= done_cnt + 1;

  // Reset values of every field
  task automatic init_model();
    foreach (wait_f[i]) wait_f[i] = '0;
    wait_f[0]  = 20'd21;    // 01_01_01
    wait_f[1]  = 20'd42;    // 10_10_10
    wait_f[11] = 20'd5888;  // 11.5
    wait_f[12] = 20'd5376;  // 10.5
    wait_f[13] = 20'd368;
    wait_f[14] = 20'h69D;   // -355 as 11 bits
    wait_f[15] = 20'd177;
    wait_f[16] = 20'd184;
    live_f = wait_f;
  endtask

  // Expected output for a raw code widened to SQ10.10
  function automatic logic [19:0] expect_out(input int idx, input logic [19:0] raw);
    int v;
    if (idx == 11 || idx == 12) return 20'(raw[14:0]) << 1;  // Position doubled
    if (idx >= 13) begin
      v = raw[10] ? int'(raw[10:0]) - 2048 : int'(raw[10:0]);  // Signed 11-bit value
      return 20'(v * 2);
    end
    return raw;
  endfunction

  // Waiting bank update for one completed frame
  task automatic model_frame(input int cmd, input logic [73:0] d);
    case (cmd)
      `CMD_SKY:    wait_f[0] = 20'(d[5:0]);
      `CMD_FLOOR:  wait_f[1] = 20'(d[5:0]);
      `CMD_LEAK:   wait_f[2] = 20'(d[5:0]);
      `CMD_OTHER: begin
        wait_f[3] = 20'(d[11:6]);  // X sent first
        wait_f[4] = 20'(d[5:0]);
      end
      `CMD_VSHIFT: wait_f[5] = 20'(d[5:0]);
      `CMD_VINF:   wait_f[6] = 20'(d[0]);
      `CMD_MAPD: begin
        wait_f[7]  = 20'(d[15:10]);
        wait_f[8]  = 20'(d[9:4]);
        wait_f[9]  = 20'(d[3:2]);
        wait_f[10] = 20'(d[1:0]);
      end
      `CMD_POV: begin
        wait_f[11] = 20'(d[73:59]);
        wait_f[12] = 20'(d[58:44]);
        wait_f[13] = 20'(d[43:33]);
        wait_f[14] = 20'(d[32:22]);
        wait_f[15] = 20'(d[21:11]);
        wait_f[16] = 20'(d[10:0]);
      end
      default: ;  // Unused codes write nothing
    endcase
  endtask

  function automatic logic [73:0] rand_payload();
    return {10'($urandom), $urandom, $urandom};
  endfunction

  // Sends nsend bits made of the command, len payload bits and random filler
  task automatic send_frame(input logic [3:0] cmd, input logic [73:0] d,
                            input int len, input int nsend);
    int   start;
    int   t;
    logic b;
    start = done_cnt;
    @(negedge clk) i_ss_n = 1'b0;
    for (int i = 0; i < nsend; i++) begin
      if (i < 4) b = cmd[3-i];                  // MSB first
      else if (i < 4 + len) b = d[len-1-(i-4)];
      else b = 1'($urandom);                    // Beyond the frame
      i_mosi = b;
      i_sclk = 1'b0;
      repeat (4) @(negedge clk);
      i_sclk = 1'b1;
      repeat (4) @(negedge clk);
    end
    t = 0;
    if (nsend >= 4 + len) begin
      while (done_cnt == start && t < DONE_WAIT) begin
        @(negedge clk);
        t++;
      end
      if (done_cnt == start) begin
        errors++;
        $display("Timeout: no frame done pulse for command %0d", cmd);
      end else begin
        model_frame(cmd, d);
      end
    end
    i_sclk = 1'b0;
    i_ss_n = 1'b1;
    repeat (4) @(negedge clk);  // Deselect long enough for the synchroniser
    if (done_cnt != start + ((nsend >= 4 + len) ? 1 : 0)) begin
      errors++;
      $display("ERROR frame_done cmd %0d: expected %0d pulses, actual %0d",
               cmd, (nsend >= 4 + len) ? 1 : 0, done_cnt - start);
    end
  endtask

  task automatic load_strobe();
    @(negedge clk) i_load_new = 1'b1;
    @(negedge clk) i_load_new = 1'b0;
    live_f = wait_f;  // Whole bank goes live
  endtask

  task automatic check_all(input string test);
    logic [19:0] act [NF];
    logic [19:0] exp;
    act = '{20'(o_sky), 20'(o_floor), 20'(o_leak), 20'(o_otherx), 20'(o_othery),
            20'(o_vshift), 20'(o_vinf), 20'(o_mapdx), 20'(o_mapdy), 20'(o_mapdxw),
            20'(o_mapdyw), o_player_x, o_player_y, o_facing_x, o_facing_y,
            o_vplane_x, o_vplane_y};
    for (int i = 0; i < NF; i++) begin
      exp = expect_out(i, live_f[i]);
      if (act[i] !== exp) begin
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", test, field_name[i], exp, act[i]);
      end
    end
  endtask

  task automatic test_single_fields();
    int cmds [5] = '{`CMD_SKY, `CMD_FLOOR, `CMD_LEAK, `CMD_VSHIFT, `CMD_VINF};
    int lens [5] = '{`LEN_SKY, `LEN_FLOOR, `LEN_LEAK, `LEN_VSHIFT, `LEN_VINF};
    for (int i = 0; i < 5; i++) begin
      send_frame(4'(cmds[i]), rand_payload(), lens[i], 4 + lens[i]);
      check_all("single_held");  // Nothing live yet
      load_strobe();
      check_all("single_live");
    end
  endtask

  // Several frames before one strobe
  task automatic test_batch();
    send_frame(`CMD_OTHER, rand_payload(), `LEN_OTHER, 4 + `LEN_OTHER);
    send_frame(`CMD_MAPD, rand_payload(), `LEN_MAPD, 4 + `LEN_MAPD);
    send_frame(`CMD_FLOOR, rand_payload(), `LEN_FLOOR, 4 + `LEN_FLOOR);
    check_all("batch_held");
    load_strobe();
    check_all("batch_live");
  endtask

  task automatic test_pov();
    logic [73:0] d;
    for (int k = 0; k < 2; k++) begin
      d = rand_payload();
      d[43] = 1'b1;  // facing_x negative
      d[10] = 1'b1;  // vplane_y negative
      if (k == 1) begin
        d[32] = 1'b1;  // All four negative on the second pass
        d[21] = 1'b1;
      end
      send_frame(`CMD_POV, d, `LEN_POV, 4 + `LEN_POV);
      check_all("pov_held");
      load_strobe();
      check_all("pov_live");
    end
  endtask

  task automatic test_ignored();
    send_frame(`CMD_SKY, rand_payload(), `LEN_SKY, 4 + `LEN_SKY - 3);  // Aborted early
    load_strobe();
    check_all("abort");
    send_frame(4'd8, rand_payload(), 1, 5);  // Unused code
    load_strobe();
    check_all("unknown_cmd");
    send_frame(`CMD_LEAK, rand_payload(), `LEN_LEAK, 4 + `LEN_LEAK + 5);  // Trailing bits
    load_strobe();
    check_all("extra_bits");
  endtask

  initial begin
    void'($urandom(43));
    i_sclk     = 1'b0;
    i_ss_n     = 1'b1;
    i_mosi     = 1'b0;
    i_load_new = 1'b0;
    reset      = 1'b1;
    init_model();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_all("reset");
    test_single_fields();
    test_batch();
    test_pov();
    test_ignored();
    assert_fails = UUT.u_rx.rx_checks.fails + UUT.u_live.live_checks.fails;
    $display("Checks finished with %0d errors and %0d assertion failures",
             errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

/* verif/spi_registers_asserts.sv */
`timescale 1ns/10ps

module spi_registers_asserts #(
  parameter int LIVE_W  = 1,    // Width of the packed live outputs
  parameter bit RX_SIDE = 1'b1  // Selects receiver checks over live bank checks
) (
  input logic              clk,
  input logic              reset,
  input logic              frame_done,
  input logic              ss_n_sync,   // Synchronised select
  input logic              load_new,
  input logic [LIVE_W-1:0] live_word    // All live outputs together
);

  int fails = 0;  // Failed assertions in this instance

  if (RX_SIDE) begin : g_rx
    // Done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
      frame_done |=> !frame_done)
      else begin
        fails++;
        $error("Frame done stayed high for more than one cycle");
      end

    done_when_selected: assert property (@(posedge clk) disable iff (reset)
      ss_n_sync |-> !frame_done)
      else begin
        fails++;
        $error("Frame done high while SS_n deselected");
      end
  end else begin : g_live
    // Live bank only moves on the strobe
    live_stable: assert property (@(posedge clk) disable iff (reset)
      !load_new |=> $stable(live_word))
      else begin
        fails++;
        $error("Live outputs changed without a load strobe");
      end
  end

endmodule

// Receiver done pulse checks with the live ports tied off
bind spi_frame_rx spi_registers_asserts #(.RX_SIDE(1'b1)) rx_checks (
  .clk        (clk),
  .reset      (reset),
  .frame_done (o_frame_done),
  .ss_n_sync  (ss_n_sync),
  .load_new   (1'b1),
  .live_word  (1'b0)
);

bind live_regs spi_registers_asserts #(.LIVE_W(173), .RX_SIDE(1'b0)) live_checks (
  .clk        (clk),
  .reset      (reset),
  .frame_done (1'b0),
  .ss_n_sync  (1'b0),
  .load_new   (i_load_new),
  .live_word  ({o_sky, o_floor, o_leak, o_otherx, o_othery, o_vshift, o_vinf,
                o_mapdx, o_mapdy, o_mapdxw, o_mapdyw, o_player_x, o_player_y,
                o_facing_x, o_facing_y, o_vplane_x, o_vplane_y})
);

/* hw/spi_registers.sv */
`timescale 1ns/10ps

module spi_registers (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_sclk,      // SPI from host
  input  logic                 i_ss_n,
  input  logic                 i_mosi,
  input  logic                 i_load_new,  // Waiting values may go live
  output raybox_pkg::rgb_t     o_sky,
  output raybox_pkg::rgb_t     o_floor,
  output raybox_pkg::cell_t    o_leak,
  output raybox_pkg::cell_t    o_otherx,
  output raybox_pkg::cell_t    o_othery,
  output raybox_pkg::cell_t    o_vshift,
  output logic                 o_vinf,
  output raybox_pkg::cell_t    o_mapdx,
  output raybox_pkg::cell_t    o_mapdy,
  output raybox_pkg::wall_id_t o_mapdxw,
  output raybox_pkg::wall_id_t o_mapdyw,
  output raybox_pkg::fix_t     o_player_x,
  output raybox_pkg::fix_t     o_player_y,
  output raybox_pkg::fix_t     o_facing_x,
  output raybox_pkg::fix_t     o_facing_y,
  output raybox_pkg::fix_t     o_vplane_x,
  output raybox_pkg::fix_t     o_vplane_y
);
  import raybox_pkg::*;

  logic     frame_done;
  cmd_t     cmd;
  payload_t payload;

  settings_if bank ();  // Waiting bank

  // Decode SPI frames
  spi_frame_rx u_rx (
    .clk          (clk),
    .reset        (reset),
    .i_sclk       (i_sclk),
    .i_ss_n       (i_ss_n),
    .i_mosi       (i_mosi),
    .o_frame_done (frame_done),
    .o_cmd        (cmd),
    .o_payload    (payload)
  );

  // Execute into the waiting bank
  reg_stage u_stage (
    .clk          (clk),
    .reset        (reset),
    .i_frame_done (frame_done),
    .i_cmd        (cmd),
    .i_payload    (payload),
    .bank         (bank.stage)
  );

  live_regs u_live (
    .clk        (clk),
    .reset      (reset),
    .i_load_new (i_load_new),
    .bank       (bank.live),
    .o_sky      (o_sky),
    .o_floor    (o_floor),
    .o_leak     (o_leak),
    .o_otherx   (o_otherx),
    .o_othery   (o_othery),
    .o_vshift   (o_vshift),
    .o_vinf     (o_vinf),
    .o_mapdx    (o_mapdx),
    .o_mapdy    (o_mapdy),
    .o_mapdxw   (o_mapdxw),
    .o_mapdyw   (o_mapdyw),
    .o_player_x (o_player_x),
    .o_player_y (o_player_y),
    .o_facing_x (o_facing_x),
    .o_facing_y (o_facing_y),
    .o_vplane_x (o_vplane_x),
    .o_vplane_y (o_vplane_y)
  );

endmodule

/* hw/live_regs.sv */
`timescale 1ns/10ps
`include "raybox_config.svh"

module live_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   i_load_new,  // Strobe from video timing
  settings_if.live               bank,        // Waiting values
  output raybox_pkg::rgb_t       o_sky,
  output raybox_pkg::rgb_t       o_floor,
  output raybox_pkg::cell_t      o_leak,
  output raybox_pkg::cell_t      o_otherx,
  output raybox_pkg::cell_t      o_othery,
  output raybox_pkg::cell_t      o_vshift,
  output logic                   o_vinf,
  output raybox_pkg::cell_t      o_mapdx,
  output raybox_pkg::cell_t      o_mapdy,
  output raybox_pkg::wall_id_t   o_mapdxw,
  output raybox_pkg::wall_id_t   o_mapdyw,
  output raybox_pkg::fix_t       o_player_x,  // Widened to SQ10.10
  output raybox_pkg::fix_t       o_player_y,
  output raybox_pkg::fix_t       o_facing_x,
  output raybox_pkg::fix_t       o_facing_y,
  output raybox_pkg::fix_t       o_vplane_x,
  output raybox_pkg::fix_t       o_vplane_y
);
  import raybox_pkg::*;

  // Live point of view, still in its packed form
  pos_t player_x_q, player_y_q;
  dir_t facing_x_q, facing_y_q;
  dir_t vplane_x_q, vplane_y_q;

  // Position is never negative, so zero pad both ends
  function automatic fix_t widen_pos(input pos_t p);
    return fix_t'({{(`FIX_INT-`POS_INT){1'b0}}, p, {(`FIX_FRAC-`POS_FRAC){1'b0}}});
  endfunction

  // Sign bit repeated above, one extra copy replaces the dropped integer bit
  function automatic fix_t widen_dir(input dir_t d);
    return fix_t'({{(`FIX_INT-`DIR_INT+1){d[`DIR_INT+`DIR_FRAC-1]}},
                   d[`DIR_INT+`DIR_FRAC-2:0],
                   {(`FIX_FRAC-`DIR_FRAC){1'b0}}});
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      o_sky      <= rgb_t'(`SKY_INIT);
      o_floor    <= rgb_t'(`FLOOR_INIT);
      o_leak     <= '0;
      o_otherx   <= '0;
      o_othery   <= '0;
      o_vshift   <= '0;
      o_vinf     <= 1'b0;
      o_mapdx    <= '0;
      o_mapdy    <= '0;
      o_mapdxw   <= '0;
      o_mapdyw   <= '0;
      player_x_q <= pos_t'(`PLAYER_X_INIT);  // Demo start position
      player_y_q <= pos_t'(`PLAYER_Y_INIT);
      facing_x_q <= dir_t'(`FACING_X_INIT);
      facing_y_q <= dir_t'(`FACING_Y_INIT);
      vplane_x_q <= dir_t'(`VPLANE_X_INIT);
      vplane_y_q <= dir_t'(`VPLANE_Y_INIT);
    end else if (i_load_new) begin
      // Whole bank goes live together
      o_sky      <= bank.sky;
      o_floor    <= bank.floor;
      o_leak     <= bank.leak;
      o_otherx   <= bank.otherx;
      o_othery   <= bank.othery;
      o_vshift   <= bank.vshift;
      o_vinf     <= bank.vinf;
      o_mapdx    <= bank.mapdx;
      o_mapdy    <= bank.mapdy;
      o_mapdxw   <= bank.mapdxw;
      o_mapdyw   <= bank.mapdyw;
      player_x_q <= bank.player_x;
      player_y_q <= bank.player_y;
      facing_x_q <= bank.facing_x;
      facing_y_q <= bank.facing_y;
      vplane_x_q <= bank.vplane_x;
      vplane_y_q <= bank.vplane_y;
    end
  end

  assign o_player_x = widen_pos(player_x_q);
  assign o_player_y = widen_pos(player_y_q);
  assign o_facing_x = widen_dir(facing_x_q);
  assign o_facing_y = widen_dir(facing_y_q);
  assign o_vplane_x = widen_dir(vplane_x_q);
  assign o_vplane_y = widen_dir(vplane_y_q);

endmodule

/* hw/reg_stage.sv */
`timescale 1ns/10ps
`include "raybox_config.svh"

module reg_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_frame_done,  // Frame complete, execute it
  input  raybox_pkg::cmd_t     i_cmd,
  input  raybox_pkg::payload_t i_payload,
  settings_if.stage            bank           // Waiting values
);
  import raybox_pkg::*;

  // Waiting bank lives in the interface signals, only this block writes it
  always_ff @(posedge clk) begin
    if (reset) begin
      // Same defaults as the live bank
      bank.sky      <= rgb_t'(`SKY_INIT);
      bank.floor    <= rgb_t'(`FLOOR_INIT);
      bank.leak     <= '0;
      bank.otherx   <= '0;
      bank.othery   <= '0;
      bank.vshift   <= '0;
      bank.vinf     <= 1'b0;
      bank.mapdx    <= '0;
      bank.mapdy    <= '0;
      bank.mapdxw   <= '0;
      bank.mapdyw   <= '0;
      bank.player_x <= pos_t'(`PLAYER_X_INIT);
      bank.player_y <= pos_t'(`PLAYER_Y_INIT);
      bank.facing_x <= dir_t'(`FACING_X_INIT);
      bank.facing_y <= dir_t'(`FACING_Y_INIT);
      bank.vplane_x <= dir_t'(`VPLANE_X_INIT);
      bank.vplane_y <= dir_t'(`VPLANE_Y_INIT);
    end else if (i_frame_done) begin
      // First bit sent lands in the MSB of each group
      case (i_cmd)
        `CMD_SKY:    bank.sky    <= i_payload[`LEN_SKY-1:0];
        `CMD_FLOOR:  bank.floor  <= i_payload[`LEN_FLOOR-1:0];
        `CMD_LEAK:   bank.leak   <= i_payload[`LEN_LEAK-1:0];
        `CMD_OTHER: begin
          {bank.otherx,
           bank.othery} <= i_payload[`LEN_OTHER-1:0];
        end
        `CMD_VSHIFT: bank.vshift <= i_payload[`LEN_VSHIFT-1:0];
        `CMD_VINF:   bank.vinf   <= i_payload[0];
        `CMD_MAPD: begin
          // Cells first, then their wall IDs
          {bank.mapdx,
           bank.mapdy,
           bank.mapdxw,
           bank.mapdyw} <= i_payload[`LEN_MAPD-1:0];
        end
        `CMD_POV: begin
          // Whole point of view in one go
          {bank.player_x,
           bank.player_y,
           bank.facing_x,
           bank.facing_y,
           bank.vplane_x,
           bank.vplane_y} <= i_payload[`LEN_POV-1:0];
        end
        default: ;  // Unused codes are ignored
      endcase
    end
  end

endmodule

/* hw/spi_frame_rx.sv */
`timescale 1ns/10ps
`include "raybox_config.svh"

module spi_frame_rx (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_sclk,        // SPI pins, asynchronous to clk
  input  logic                 i_ss_n,
  input  logic                 i_mosi,
  output logic                 o_frame_done,  // One-cycle pulse
  output raybox_pkg::cmd_t     o_cmd,
  output raybox_pkg::payload_t o_payload      // Last bit received is bit 0
);
  import raybox_pkg::*;

  // Enough for command plus longest payload
  localparam int CNT_W = $clog2(`CMD_BITS + `PAYLOAD_BITS + 1);

  logic [2:0]       sclk_sync;   // Third stage for edge detect
  logic [1:0]       ss_n_pipe;
  logic [1:0]       mosi_pipe;
  logic             sclk_rise;
  logic             ss_n_sync;
  logic             mosi_bit;
  rx_state_t        state;
  logic [CNT_W-1:0] bit_cnt;     // Bits taken so far in this frame
  logic [CNT_W-1:0] frame_len;   // Command plus payload
  logic             frame_end;

  always_ff @(posedge clk) begin
    if (reset) begin
      sclk_sync <= '0;
      ss_n_pipe <= '1;           // Deselected
    end else begin
      sclk_sync <= {sclk_sync[1:0], i_sclk};
      ss_n_pipe <= {ss_n_pipe[0], i_ss_n};
    end
  end

  // Data pin only, lines up with the SCLK edge detect
  always_ff @(posedge clk) begin
    mosi_pipe <= {mosi_pipe[0], i_mosi};
  end

  assign sclk_rise = (sclk_sync[2:1] == 2'b01);
  assign ss_n_sync = ss_n_pipe[1];
  assign mosi_bit  = mosi_pipe[1];

  // Frame length from the received command
  always_comb begin
    case (o_cmd)
      `CMD_SKY:    frame_len = CNT_W'(`CMD_BITS + `LEN_SKY);
      `CMD_FLOOR:  frame_len = CNT_W'(`CMD_BITS + `LEN_FLOOR);
      `CMD_LEAK:   frame_len = CNT_W'(`CMD_BITS + `LEN_LEAK);
      `CMD_OTHER:  frame_len = CNT_W'(`CMD_BITS + `LEN_OTHER);
      `CMD_VSHIFT: frame_len = CNT_W'(`CMD_BITS + `LEN_VSHIFT);
      `CMD_MAPD:   frame_len = CNT_W'(`CMD_BITS + `LEN_MAPD);
      `CMD_POV:    frame_len = CNT_W'(`CMD_BITS + `LEN_POV);
      default:     frame_len = CNT_W'(`CMD_BITS + `LEN_VINF); // VINF and unused codes
    endcase
  end

  assign frame_end = (bit_cnt == frame_len - 1'b1);

  always_ff @(posedge clk) begin
    if (reset || ss_n_sync) begin  // Everything held clear while deselected
      state        <= RX_IDLE;
      bit_cnt      <= '0;
      o_cmd        <= '0;
      o_frame_done <= 1'b0;
    end else begin
      o_frame_done <= 1'b0;
      case (state)
        RX_IDLE, RX_CMD: begin
          state <= RX_CMD;
          if (sclk_rise) begin
            o_cmd   <= {o_cmd[`CMD_BITS-2:0], mosi_bit};  // MSB first
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == CNT_W'(`CMD_BITS - 1))
              state <= RX_PAYLOAD;
          end
        end
        RX_PAYLOAD: begin
          if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (frame_end) begin
              o_frame_done <= 1'b1;
              state        <= RX_STALL;
            end
          end
        end
        default: ;  // Stalled until SS_n goes high
      endcase
    end
  end

  // Payload shift, holds once stalled
  always_ff @(posedge clk) begin
    if (!ss_n_sync && state == RX_PAYLOAD && sclk_rise)
      o_payload <= {o_payload[`PAYLOAD_BITS-2:0], mosi_bit};
  end

endmodule

/* hw/settings_if.sv */
`timescale 1ns/10ps

// Waiting register bank, written by reg_stage and read by live_regs
interface settings_if;
  import raybox_pkg::*;

  rgb_t     sky, floor;
  cell_t    leak;
  cell_t    otherx, othery;   // Other map cell
  cell_t    vshift;           // Texture V addend
  logic     vinf;             // Infinite V
  cell_t    mapdx, mapdy;     // Dividing walls, 0 is none
  wall_id_t mapdxw, mapdyw;
  pos_t     player_x, player_y;
  dir_t     facing_x, facing_y;
  dir_t     vplane_x, vplane_y;

  modport stage (
    output sky, floor, leak, otherx, othery, vshift, vinf,
    output mapdx, mapdy, mapdxw, mapdyw,
    output player_x, player_y, facing_x, facing_y, vplane_x, vplane_y
  );

  modport live (
    input sky, floor, leak, otherx, othery, vshift, vinf,
    input mapdx, mapdy, mapdxw, mapdyw,
    input player_x, player_y, facing_x, facing_y, vplane_x, vplane_y
  );

endinterface

/* hw/raybox_pkg.sv */
`include "raybox_config.svh"

package raybox_pkg;

  // Colour, 2 bits each for R, G, B
  typedef logic [`RGB_BITS-1:0] rgb_t;

  // Map cell coordinate, also used for leak and V shift amounts
  typedef logic [`CELL_BITS-1:0] cell_t;

  typedef logic [`WALL_BITS-1:0] wall_id_t;  // Wall texture ID

  // SPI frame fields
  typedef logic [`CMD_BITS-1:0] cmd_t;
  typedef logic [`PAYLOAD_BITS-1:0] payload_t;

  // Player position, unsigned, range [0,64)
  typedef logic [`POS_INT+`POS_FRAC-1:0] pos_t;

  // Facing and view plane vectors, range [-2.0,+2.0)
  typedef logic signed [`DIR_INT+`DIR_FRAC-1:0] dir_t;

  // Vector format used by the renderer
  typedef logic signed [`FIX_INT+`FIX_FRAC-1:0] fix_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,     // SS_n high
    RX_CMD,      // Shifting command bits
    RX_PAYLOAD,  // Shifting payload bits
    RX_STALL     // Frame complete, extra bits ignored
  } rx_state_t;

endpackage

/* hw/raybox_config.svh */
`ifndef RAYBOX_CONFIG_SVH
`define RAYBOX_CONFIG_SVH

// Frame layout
`define CMD_BITS      4
`define PAYLOAD_BITS  74  // Longest payload is POV

// Command codes
`define CMD_SKY       0
`define CMD_FLOOR     1
`define CMD_LEAK      2
`define CMD_OTHER     3
`define CMD_VSHIFT    4
`define CMD_VINF      5
`define CMD_MAPD      6
`define CMD_POV       11  // Codes 7..10 and 12..15 are unused

// Payload lengths in bits
`define LEN_SKY       6
`define LEN_FLOOR     6
`define LEN_LEAK      6
`define LEN_OTHER     12  // X then Y
`define LEN_VSHIFT    6
`define LEN_VINF      1
`define LEN_MAPD      16  // dx, dy, dxw, dyw
`define LEN_POV       74  // 2 x 15 + 4 x 11

// Field widths
`define RGB_BITS      6   // 2 bits per channel
`define CELL_BITS     6
`define WALL_BITS     2
`define POS_INT       6   // Player position UQ6.9
`define POS_FRAC      9
`define DIR_INT       2   // Direction vectors SQ2.9
`define DIR_FRAC      9
`define FIX_INT       10  // Renderer format SQ10.10
`define FIX_FRAC      10

// Reset defaults
`define SKY_INIT      21  // 6'b01_01_01
`define FLOOR_INIT    42  // 6'b10_10_10
`define PLAYER_X_INIT 5888  // 11.5 with 9 fraction bits
`define PLAYER_Y_INIT 5376  // 10.5
`define FACING_X_INIT 368
`define FACING_Y_INIT (-355)
`define VPLANE_X_INIT 177
`define VPLANE_Y_INIT 184

`endif
